/* hdl/led_matrix_pkg.sv */
/*
 * Shared geometry, brightness and timing constants for the LED matrix scan
 * design, plus the pixel, host write and panel pin structs.
 */
package led_matrix_pkg;

    // panel geometry, one half of the panel is PIXEL_HALFHEIGHT rows
    localparam int unsigned PIXEL_WIDTH      = 8;
    localparam int unsigned PIXEL_HALFHEIGHT = 4;

    // bits per colour channel, also the number of bit-planes
    localparam int unsigned BRIGHTNESS_LEVELS       = 4;
    // enable cycles of the lsb plane, doubled per plane
    localparam int unsigned BRIGHTNESS_BASE_TIMEOUT = 4;
    // the shift phase fits exactly in the last BRIGHTNESS_OVERLAP enable cycles
    localparam int unsigned BRIGHTNESS_OVERLAP      = 2 * PIXEL_WIDTH;

    localparam int unsigned COLUMN_BITS = $clog2(PIXEL_WIDTH);
    localparam int unsigned ROW_BITS    = $clog2(PIXEL_HALFHEIGHT);
    // one half of the frame, indexed {row, column}
    localparam int unsigned BANK_BITS   = ROW_BITS + COLUMN_BITS;
    // host address {half, row, column}, half set for the lower half
    localparam int unsigned ADDR_BITS   = BANK_BITS + 1;

    // shift phase length and its counter width
    localparam int unsigned SHIFT_CYCLES = 2 * PIXEL_WIDTH;
    localparam int unsigned SHIFT_BITS   = $clog2(SHIFT_CYCLES + 1);

    // longest enable window, msb plane
    localparam int unsigned MAX_ENABLE  = BRIGHTNESS_BASE_TIMEOUT << (BRIGHTNESS_LEVELS - 1);
    localparam int unsigned ENABLE_BITS = $clog2(MAX_ENABLE + 1);

    localparam logic [BRIGHTNESS_LEVELS-1:0] MSB_PLANE = 1 << (BRIGHTNESS_LEVELS - 1);

    typedef struct packed {
        logic [BRIGHTNESS_LEVELS-1:0] red;
        logic [BRIGHTNESS_LEVELS-1:0] green;
        logic [BRIGHTNESS_LEVELS-1:0] blue;
    } pixel_t;

    typedef struct packed {
        logic [ADDR_BITS-1:0] address;
        pixel_t               pixel;
    } pixel_write_t;

    // rgb bits are ordered {red, green, blue}
    typedef struct packed {
        logic [2:0]             rgb_upper;
        logic [2:0]             rgb_lower;
        logic [ROW_BITS-1:0]    row_address;
        logic [COLUMN_BITS-1:0] column_address;
        logic                   pixel_clk;
        logic                   row_latch;
        logic                   output_enable;
    } panel_out_t;

endpackage

/* hdl/scan_timer.sv */
/*
 * Loadable down-counter with a running flag. Start loads the count, and
 * running stays high for exactly load_value cycles afterwards.
 */
`timescale 1ns/1ps

module scan_timer #(
    parameter int unsigned COUNTER_WIDTH = 8
) (
    input  logic                     clk_in,
    input  logic                     reset,
    input  logic                     start,
    input  logic [COUNTER_WIDTH-1:0] load_value,
    output logic [COUNTER_WIDTH-1:0] count,
    output logic                     running
);

    // start wins over counting, so a restart mid-run reloads
    always_ff @(posedge clk_in) begin
        if (reset) begin
            count <= '0;
        end else if (start) begin
            count <= load_value;
        end else if (running) begin
            count <= count - COUNTER_WIDTH'(1);
        end
    end

    // idle once the count has run out
    assign running = (count != '0);

endmodule

/* hdl/brightness_timer.sv */
/*
 * Output-enable window for one bit-plane. Loaded by row_latch with a length
 * weighted by the plane, it also flags when the next shift phase may start.
 */
`timescale 1ns/1ps

module brightness_timer (
    input  logic                                         clk_in,
    input  logic                                         reset,
    input  logic                                         row_latch,
    input  logic [led_matrix_pkg::BRIGHTNESS_LEVELS-1:0] plane_mask,
    output logic                                         output_enable,
    output logic                                         overlap_reached
);
    import led_matrix_pkg::*;

    logic [ENABLE_BITS-1:0] enable_count;
    logic [ENABLE_BITS-1:0] window_length;

    // base timeout shifted by the index of the one-hot mask
    always_comb begin
        window_length = '0;
        for (int i = 0; i < BRIGHTNESS_LEVELS; i++) begin
            if (plane_mask[i]) begin
                window_length = ENABLE_BITS'(BRIGHTNESS_BASE_TIMEOUT << i);
            end
        end
    end

    // count remaining enable cycles
    always_ff @(posedge clk_in) begin
        if (reset) begin
            enable_count <= '0;
        end else if (row_latch) begin
            enable_count <= window_length;
        end else if (output_enable) begin
            enable_count <= enable_count - ENABLE_BITS'(1);
        end
    end

    // leds on one cycle after the latch, for window_length cycles
    assign output_enable = (enable_count != '0);

    // short windows are past the overlap point from their first cycle
    assign overlap_reached = (enable_count <= ENABLE_BITS'(BRIGHTNESS_OVERLAP));

endmodule

/* hdl/matrix_scan.sv */
/*
 * Scan sequencer. Runs the column shift phase, latches the row, steps the
 * bit-plane from msb to lsb and then moves to the next row.
 */
`timescale 1ns/1ps

module matrix_scan (
    input  logic                                         clk_in,
    input  logic                                         reset,
    output logic                                         read_strobe,
    output logic [led_matrix_pkg::COLUMN_BITS-1:0]       read_column,
    output logic [led_matrix_pkg::ROW_BITS-1:0]          read_row,
    output logic                                         row_latch,
    output logic                                         output_enable,
    output logic [led_matrix_pkg::ROW_BITS-1:0]          row_address,
    output logic [led_matrix_pkg::BRIGHTNESS_LEVELS-1:0] brightness_mask
);
    import led_matrix_pkg::*;

    logic [SHIFT_BITS-1:0] shift_count;
    logic                  shift_running;
    logic                  running_q;
    logic                  shift_done;
    logic                  shift_busy;
    logic                  shift_ready;
    logic                  start_shift;
    logic [1:0]            start_history;
    logic                  overlap_reached;

    // shift phase timer, 2 cycles per column
    scan_timer #(
        .COUNTER_WIDTH(SHIFT_BITS)
    ) shift_timer_i (
        .clk_in    (clk_in),
        .reset     (reset),
        .start     (start_shift),
        .load_value(SHIFT_BITS'(SHIFT_CYCLES)),
        .count     (shift_count),
        .running   (shift_running)
    );

    // strobe on even counts
    assign read_strobe = shift_running && !shift_count[0];
    // count 2c+2 strobes column c, count 2c+1 is its read data cycle
    // so the column holds through both and lines up with data_valid
    assign read_column = COLUMN_BITS'((shift_count - SHIFT_BITS'(1)) >> 1);

    // window idle or in its tail, and no phase in flight
    assign shift_ready = (!output_enable || overlap_reached) && !shift_busy;
    // rising edge of ready, one cycle late
    assign start_shift = (start_history == 2'b01);
    // running just fell, the last strobe was two cycles ago
    assign shift_done  = running_q && !shift_running;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            start_history   <= 2'b00;
            running_q       <= 1'b0;
            row_latch       <= 1'b0;
            shift_busy      <= 1'b0;
            read_row        <= '0;
            row_address     <= '0;
            brightness_mask <= MSB_PLANE;
        end else begin
            start_history <= {start_history[0], shift_ready};
            running_q     <= shift_running;
            // latch lands with the last pixel clock
            row_latch     <= shift_done;

            // busy from start until the row has been latched
            if (start_shift) begin
                shift_busy <= 1'b1;
            end else if (row_latch) begin
                shift_busy <= 1'b0;
            end

            // hand the shifted row to the enable stage, then step
            if (row_latch) begin
                row_address <= read_row;
                if (brightness_mask[0]) begin
                    brightness_mask <= MSB_PLANE;
                    if (read_row == ROW_BITS'(PIXEL_HALFHEIGHT - 1)) begin
                        read_row <= '0;
                    end else begin
                        read_row <= read_row + ROW_BITS'(1);
                    end
                end else begin
                    brightness_mask <= brightness_mask >> 1;
                end
            end
        end
    end

    // window length follows the plane being latched
    brightness_timer brightness_timer_i (
        .clk_in         (clk_in),
        .reset          (reset),
        .row_latch      (row_latch),
        .plane_mask     (brightness_mask),
        .output_enable  (output_enable),
        .overlap_reached(overlap_reached)
    );

endmodule

/* hdl/frame_buffer.sv */
/*
 * Pixel memory for the whole panel. The host writes one pixel per strobe;
 * the scan side reads the same row of both halves in one registered access.
 */
`timescale 1ns/1ps

module frame_buffer (
    input  logic                                   clk_in,
    input  logic                                   write_strobe,
    input  led_matrix_pkg::pixel_write_t           write_data,
    input  logic                                   read_strobe,
    input  logic [led_matrix_pkg::COLUMN_BITS-1:0] read_column,
    input  logic [led_matrix_pkg::ROW_BITS-1:0]    read_row,
    output led_matrix_pkg::pixel_t                 upper_pixel,
    output led_matrix_pkg::pixel_t                 lower_pixel,
    output logic                                   data_valid
);
    import led_matrix_pkg::*;

    // one bank per panel half, indexed {row, column}
    pixel_t upper_mem [2**BANK_BITS];
    pixel_t lower_mem [2**BANK_BITS];

    logic                 write_lower;
    logic [BANK_BITS-1:0] write_index;
    logic [BANK_BITS-1:0] read_index;

    // top address bit picks the half
    assign write_lower = write_data.address[ADDR_BITS-1];
    assign write_index = write_data.address[BANK_BITS-1:0];
    assign read_index  = {read_row, read_column};

    // host port, no back-pressure
    always_ff @(posedge clk_in) begin
        if (write_strobe && !write_lower) begin
            upper_mem[write_index] <= write_data.pixel;
        end
        if (write_strobe && write_lower) begin
            lower_mem[write_index] <= write_data.pixel;
        end
    end

    // scan port, data one cycle after the strobe
    always_ff @(posedge clk_in) begin
        data_valid <= read_strobe;
        if (read_strobe) begin
            upper_pixel <= upper_mem[read_index];
            lower_pixel <= lower_mem[read_index];
        end
    end

endmodule

/* hdl/pixel_shifter.sv */
/*
 * Picks the current bit-plane out of each colour for both panel halves and
 * registers the data bits and column, with a pixel clock pulse a cycle later.
 */
`timescale 1ns/1ps

module pixel_shifter (
    input  logic                                         clk_in,
    input  logic                                         reset,
    input  led_matrix_pkg::pixel_t                       upper_pixel,
    input  led_matrix_pkg::pixel_t                       lower_pixel,
    input  logic                                         data_valid,
    input  logic [led_matrix_pkg::BRIGHTNESS_LEVELS-1:0] brightness_mask,
    input  logic [led_matrix_pkg::COLUMN_BITS-1:0]       read_column_delayed,
    output logic [2:0]                                   rgb_upper,
    output logic [2:0]                                   rgb_lower,
    output logic [led_matrix_pkg::COLUMN_BITS-1:0]       column_address,
    output logic                                         pixel_clk
);
    import led_matrix_pkg::*;

    logic load_q;

    // one-hot mask, so the or-reduce yields the selected bit
    function automatic logic [2:0] plane_bits(pixel_t pixel, logic [BRIGHTNESS_LEVELS-1:0] mask);
        plane_bits = {|(pixel.red & mask), |(pixel.green & mask), |(pixel.blue & mask)};
    endfunction

    // data bits and column
    always_ff @(posedge clk_in) begin
        if (data_valid) begin
            rgb_upper      <= plane_bits(upper_pixel, brightness_mask);
            rgb_lower      <= plane_bits(lower_pixel, brightness_mask);
            column_address <= read_column_delayed;
        end
    end

    // clock one cycle behind the data, so bits settle first
    always_ff @(posedge clk_in) begin
        if (reset) begin
            load_q    <= 1'b0;
            pixel_clk <= 1'b0;
        end else begin
            load_q    <= data_valid;
            pixel_clk <= load_q;
        end
    end

endmodule

/* hdl/led_matrix_top.sv */
/*
 * Top level of the LED matrix scan subsystem. Host pixel writes go in,
 * HUB75-style panel pins come out as one packed struct.
 */
`timescale 1ns/1ps

module led_matrix_top (
    input  logic                         clk_in,
    input  logic                         reset,
    input  logic                         write_strobe,
    input  led_matrix_pkg::pixel_write_t write_data,
    output led_matrix_pkg::panel_out_t   panel
);
    import led_matrix_pkg::*;

    logic                         read_strobe;
    logic [COLUMN_BITS-1:0]       read_column;
    logic [ROW_BITS-1:0]          read_row;
    logic                         row_latch;
    logic                         output_enable;
    logic [ROW_BITS-1:0]          row_address;
    logic [BRIGHTNESS_LEVELS-1:0] brightness_mask;
    pixel_t                       upper_pixel;
    pixel_t                       lower_pixel;
    logic                         data_valid;
    logic [2:0]                   rgb_upper;
    logic [2:0]                   rgb_lower;
    logic [COLUMN_BITS-1:0]       column_address;
    logic                         pixel_clk;

    // producer of display positions
    matrix_scan matrix_scan_i (
        .clk_in         (clk_in),
        .reset          (reset),
        .read_strobe    (read_strobe),
        .read_column    (read_column),
        .read_row       (read_row),
        .row_latch      (row_latch),
        .output_enable  (output_enable),
        .row_address    (row_address),
        .brightness_mask(brightness_mask)
    );

    frame_buffer frame_buffer_i (
        .clk_in      (clk_in),
        .write_strobe(write_strobe),
        .write_data  (write_data),
        .read_strobe (read_strobe),
        .read_column (read_column),
        .read_row    (read_row),
        .upper_pixel (upper_pixel),
        .lower_pixel (lower_pixel),
        .data_valid  (data_valid)
    );

    // read_column still holds its column in the data_valid cycle
    pixel_shifter pixel_shifter_i (
        .clk_in             (clk_in),
        .reset              (reset),
        .upper_pixel        (upper_pixel),
        .lower_pixel        (lower_pixel),
        .data_valid         (data_valid),
        .brightness_mask    (brightness_mask),
        .read_column_delayed(read_column),
        .rgb_upper          (rgb_upper),
        .rgb_lower          (rgb_lower),
        .column_address     (column_address),
        .pixel_clk          (pixel_clk)
    );

    assign panel = '{
        rgb_upper:      rgb_upper,
        rgb_lower:      rgb_lower,
        row_address:    row_address,
        column_address: column_address,
        pixel_clk:      pixel_clk,
        row_latch:      row_latch,
        output_enable:  output_enable
    };

endmodule

/* tests/led_matrix_checker.sv */
/*
 * Testbench checker. Keeps a reference frame fed from the host write port and
 * compares the panel pins with the scan rules at every falling clock edge.
 */
`timescale 1ns/1ps

module led_matrix_checker (
    input logic                         clk_in,
    input logic                         reset,
    input logic                         write_strobe,
    input led_matrix_pkg::pixel_write_t write_data,
    input led_matrix_pkg::panel_out_t   panel
);
    import led_matrix_pkg::*;

    pixel_t       frame_model [2**ADDR_BITS];
    logic         known       [2**ADDR_BITS];
    logic         redrawn     [2**ADDR_BITS];
    // a write seen here reaches a pixel clock four cycles later
    pixel_write_t pending     [4];
    logic         pending_ok  [4];
    // one counter pair per behavior
    int unsigned  checks      [6];
    int unsigned  errors      [6];

    logic                reset_q;
    logic                window_open;
    logic [ROW_BITS-1:0] shift_row;
    logic [ROW_BITS-1:0] window_row;
    int unsigned         shift_plane;
    int unsigned         pulses;
    int unsigned         window_length;
    int unsigned         enable_cycles;

    initial begin
        reset_q = 1'b0;
        for (int i = 0; i < 2**ADDR_BITS; i++) begin
            known[i]   = 1'b0;
            redrawn[i] = 1'b0;
        end
        for (int i = 0; i < 4; i++) begin
            pending_ok[i] = 1'b0;
        end
        for (int i = 0; i < 6; i++) begin
            checks[i] = 0;
            errors[i] = 0;
        end
    end

    task automatic report_value(int unsigned item, string signal, logic [31:0] expected,
                                logic [31:0] actual);
        errors[item]++;
        $display("ERROR %s: expected 0x%0h, got 0x%0h at %0t", signal, expected, actual, $time);
    endtask

    task automatic report_failure(int unsigned item, string what);
        errors[item]++;
        $display("behavior %0d went wrong at %0t: %s", item + 1, $time, what);
    endtask

    // bit k of each colour, skipped until the address has been written
    task automatic compare_half(logic [ADDR_BITS-1:0] address, logic [2:0] actual,
                                string signal);
        logic [2:0]  expected;
        int unsigned item;
        if (known[address]) begin
            expected = {frame_model[address].red[shift_plane],
                        frame_model[address].green[shift_plane],
                        frame_model[address].blue[shift_plane]};
            // rewritten pixels count as writes during display
            item = redrawn[address] ? 4 : 1;
            checks[item]++;
            if (actual !== expected) begin
                report_value(item, signal, expected, actual);
            end
        end
    endtask

    always @(negedge clk_in) begin : monitor
        logic [ADDR_BITS-1:0]   address;
        logic [COLUMN_BITS-1:0] column;
        // writes old enough to have been read by the scan side
        if (pending_ok[3]) begin
            address              = pending[3].address;
            redrawn[address]     = known[address];
            frame_model[address] = pending[3].pixel;
            known[address]       = 1'b1;
        end
        if (reset) begin
            shift_row   = '0;
            shift_plane = BRIGHTNESS_LEVELS - 1;
            pulses      = 0;
            window_open = 1'b0;
        end else begin
            // control pins leave reset low
            if (reset_q) begin
                checks[0]++;
                if ({panel.output_enable, panel.row_latch, panel.pixel_clk} !== 3'b000) begin
                    report_value(0, "{output_enable, row_latch, pixel_clk}", 0,
                                 {panel.output_enable, panel.row_latch, panel.pixel_clk});
                end
            end
            if (panel.pixel_clk === 1'b1) begin
                checks[0]++;
                checks[5]++;
                if (pulses >= PIXEL_WIDTH) begin
                    report_failure(0, "more pixel_clk pulses than columns before row_latch");
                end else begin
                    // columns run from the last one down to 0
                    column = COLUMN_BITS'(PIXEL_WIDTH - 1 - pulses);
                    if (panel.column_address !== column) begin
                        report_value(0, "column_address", column, panel.column_address);
                    end
                    compare_half({1'b0, shift_row, column}, panel.rgb_upper, "rgb_upper");
                    compare_half({1'b1, shift_row, column}, panel.rgb_lower, "rgb_lower");
                end
                pulses++;
                // only the window tail may overlap the shift
                if (panel.output_enable && window_length - enable_cycles > BRIGHTNESS_OVERLAP) begin
                    report_failure(5, "pixel_clk while more than the overlap of the window is left");
                end
            end
            // window length follows the plane, row_address the latched row
            if (window_open && panel.output_enable) begin
                enable_cycles++;
                checks[3]++;
                if (panel.row_address !== window_row) begin
                    report_value(3, "row_address", window_row, panel.row_address);
                end
            end else if (window_open) begin
                window_open = 1'b0;
                checks[2]++;
                if (enable_cycles != window_length) begin
                    report_value(2, "output_enable cycles", window_length, enable_cycles);
                end
            end else if (panel.output_enable) begin
                report_failure(2, "output_enable high without a row_latch before it");
            end
            if (panel.row_latch === 1'b1) begin
                checks[0]++;
                if (pulses != PIXEL_WIDTH) begin
                    report_value(0, "pixel_clk pulses per row", PIXEL_WIDTH, pulses);
                end
                if (window_open) begin
                    report_failure(2, "row_latch while the previous window was still open");
                end
                window_open   = 1'b1;
                window_row    = shift_row;
                window_length = BRIGHTNESS_BASE_TIMEOUT << shift_plane;
                enable_cycles = 0;
                pulses        = 0;
                // planes msb to lsb, then the next row
                if (shift_plane == 0) begin
                    shift_plane = BRIGHTNESS_LEVELS - 1;
                    shift_row   = (shift_row == ROW_BITS'(PIXEL_HALFHEIGHT - 1)) ? '0
                                                                              : shift_row + 1'b1;
                end else begin
                    shift_plane--;
                end
            end
        end
        // newest write enters the delay line
        for (int i = 3; i > 0; i--) begin
            pending[i]    = pending[i - 1];
            pending_ok[i] = pending_ok[i - 1];
        end
        pending[0]    = write_data;
        pending_ok[0] = (write_strobe === 1'b1);
        reset_q       = reset;
    end

    function automatic string behavior_name(int unsigned item);
        case (item)
            0:       return "reset and column order";
            1:       return "pixel data";
            2:       return "enable window length";
            3:       return "plane and row order";
            4:       return "writes during display";
            default: return "pixel_clk only in overlap";
        endcase
    endfunction

    // one line per behavior, totals go back to the testbench
    task automatic summarize(output int unsigned total_checks, output int unsigned total_errors);
        total_checks = 0;
        total_errors = 0;
        for (int i = 0; i < 6; i++) begin
            if (checks[i] == 0) begin
                errors[i]++;
                $display("behavior %0d (%s) was never exercised", i + 1, behavior_name(i));
            end
            $display("behavior %0d (%s): %0d checks, %0d errors", i + 1, behavior_name(i),
                     checks[i], errors[i]);
            total_checks += checks[i];
            total_errors += errors[i];
        end
    endtask

endmodule

/* tests/led_matrix_tb.sv */
/*
 * Testbench for the LED matrix scan subsystem. Preloads a random frame, then
 * writes random pixels during one frame of display and idles for one more.
 */
`timescale 1ns/1ps

module led_matrix_tb;
    import led_matrix_pkg::*;

    logic         clk_in;
    logic         reset;
    logic         write_strobe;
    pixel_write_t write_data;
    panel_out_t   panel;
    logic [31:0]  lfsr_state;
    int unsigned  latches;
    int unsigned  display_writes;
    int unsigned  total_checks;
    int unsigned  total_errors;

    led_matrix_top led_matrix_top_i (
        .clk_in      (clk_in),
        .reset       (reset),
        .write_strobe(write_strobe),
        .write_data  (write_data),
        .panel       (panel)
    );

    led_matrix_checker led_matrix_checker (
        .clk_in      (clk_in),
        .reset       (reset),
        .write_strobe(write_strobe),
        .write_data  (write_data),
        .panel       (panel)
    );

    // 10 ns period
    initial clk_in = 1'b0;
    always #5 clk_in = ~clk_in;

    // x^32 + x^22 + x^2 + x + 1, new bit shifted in at the bottom
    function automatic logic [31:0] lfsr_step(logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // one lfsr step per bit taken
    task automatic random_bits(int unsigned count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    // one host cycle, driven 1 ns after the rising edge
    task automatic host_cycle(logic strobe, logic [ADDR_BITS-1:0] address);
        logic [31:0] colour;
        @(posedge clk_in);
        #1;
        colour = '0;
        if (strobe) begin
            random_bits(3 * BRIGHTNESS_LEVELS, colour);
        end
        write_strobe       = strobe;
        write_data.address = address;
        write_data.pixel   = pixel_t'(colour[3*BRIGHTNESS_LEVELS-1:0]);
        // pins have settled by now
        if (panel.row_latch === 1'b1) begin
            latches++;
        end
    endtask

    // run until a full frame of row latches has gone by
    task automatic run_frame(logic with_writes);
        logic [31:0] choice;
        logic [31:0] address;
        latches = 0;
        while (latches < PIXEL_HALFHEIGHT * BRIGHTNESS_LEVELS) begin
            choice  = '0;
            address = '0;
            if (with_writes) begin
                random_bits(2, choice);
            end
            // about one write in four cycles
            if (choice[1:0] == 2'b11) begin
                random_bits(ADDR_BITS, address);
                display_writes++;
            end
            host_cycle(choice[1:0] == 2'b11, ADDR_BITS'(address));
        end
    endtask

    initial begin
        lfsr_state     = 32'h486e_ed1a;
        reset          = 1'b1;
        write_strobe   = 1'b0;
        write_data     = '0;
        latches        = 0;
        display_writes = 0;
        repeat (3) @(posedge clk_in);
        #1;
        reset = 1'b0;
        // every address once
        for (int i = 0; i < 2**ADDR_BITS; i++) begin
            host_cycle(1'b1, ADDR_BITS'(i));
        end
        $display("preload done: %0d pixels written", 2**ADDR_BITS);
        run_frame(1'b1);
        $display("display frame done: %0d random writes", display_writes);
        run_frame(1'b0);
        $display("idle frame done");
        led_matrix_checker.summarize(total_checks, total_errors);
        $display("checks: %0d, errors: %0d", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // reset, preload, then two frames of rows x planes x (shift + longest window)
    initial begin : watchdog
        int unsigned watchdog_cycles;
        watchdog_cycles = 3 + 2**ADDR_BITS
                        + 2 * PIXEL_HALFHEIGHT * BRIGHTNESS_LEVELS * (SHIFT_CYCLES + MAX_ENABLE);
        #(watchdog_cycles * 10);
        $display("watchdog timeout: run did not finish within %0d cycles", watchdog_cycles);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

/* filelist.f */
hdl/led_matrix_pkg.sv
hdl/scan_timer.sv
hdl/brightness_timer.sv
hdl/matrix_scan.sv
hdl/frame_buffer.sv
hdl/pixel_shifter.sv
hdl/led_matrix_top.sv
tests/led_matrix_checker.sv
tests/led_matrix_tb.sv

/* Bender.yml */
package:
  name: led_matrix

sources:
  # rtl, always included
  - files:
      - hdl/led_matrix_pkg.sv
      - hdl/scan_timer.sv
      - hdl/brightness_timer.sv
      - hdl/matrix_scan.sv
      - hdl/frame_buffer.sv
      - hdl/pixel_shifter.sv
      - hdl/led_matrix_top.sv
  - target: test
    files:
      - tests/led_matrix_checker.sv
      - tests/led_matrix_tb.sv
